/* compile.f */
logic/exec_pkg.sv
logic/issue_dispatch.sv
logic/exec_lane.sv
logic/commit_reorder.sv
logic/exec_cluster.sv
verif/exec_cluster_tb.sv

/* logic/commit_reorder.sv */
/*
 * Commit reorder buffer
 * Collects lane results in slots indexed by transaction id and
 * releases them one per cycle in program order
 */
`timescale 1ns/1ps
`default_nettype none

module commit_reorder (
    input  logic                                                    clk_i,
    input  logic                                                    rst_ni,
    input  logic                                                    flush_i,
    input  logic [exec_pkg::NR_LANES-1:0]                           done_i,
    input  logic [exec_pkg::NR_LANES*exec_pkg::TRANS_ID_BITS-1:0]   trans_id_i,
    input  logic [exec_pkg::NR_LANES*exec_pkg::REG_ADDR_BITS-1:0]   rd_i,
    input  logic [exec_pkg::NR_LANES*exec_pkg::XLEN-1:0]            result_i,
    input  logic [exec_pkg::NR_LANES-1:0]                           illegal_i,
    output logic                                                    result_valid_o,
    output logic [exec_pkg::REG_ADDR_BITS-1:0]                      result_rd_o,
    output logic [exec_pkg::XLEN-1:0]                               result_data_o,
    output logic                                                    result_illegal_o
);
    import exec_pkg::*;

    // Per-lane views of the flattened inputs
    logic [TRANS_ID_BITS-1:0] lane_tid [NR_LANES];
    logic [REG_ADDR_BITS-1:0] lane_rd  [NR_LANES];
    logic [XLEN-1:0]          lane_res [NR_LANES];

    // Slot storage
    logic [NR_ROB_ENTRIES-1:0] filled;
    logic [REG_ADDR_BITS-1:0]  slot_rd      [NR_ROB_ENTRIES];
    logic [XLEN-1:0]           slot_data    [NR_ROB_ENTRIES];
    logic                      slot_illegal [NR_ROB_ENTRIES];
    logic [TRANS_ID_BITS-1:0]  head;
    logic                      head_ready;

    always_comb begin
        for (int l = 0; l < NR_LANES; l++) begin
            lane_tid[l] = trans_id_i[l*TRANS_ID_BITS +: TRANS_ID_BITS];
            lane_rd[l]  = rd_i[l*REG_ADDR_BITS +: REG_ADDR_BITS];
            lane_res[l] = result_i[l*XLEN +: XLEN];
        end
    end

    assign head_ready = filled[head];

    // --------------------
    // Flags and head
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            filled         <= '0;
            head           <= '0;
            result_valid_o <= 1'b0;
        end else if (flush_i) begin
            filled         <= '0;
            head           <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= head_ready;
            if (head_ready) begin
                filled[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            // Never the head slot, at most six ids are in flight
            for (int l = 0; l < NR_LANES; l++) begin
                if (done_i[l]) filled[lane_tid[l]] <= 1'b1;
            end
        end
    end

    // --------------------
    // Slot and output data
    // --------------------
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < NR_LANES; l++) begin
            if (done_i[l]) begin
                slot_rd[lane_tid[l]]      <= lane_rd[l];
                slot_data[lane_tid[l]]    <= lane_res[l];
                slot_illegal[lane_tid[l]] <= illegal_i[l];
            end
        end
        if (head_ready) begin
            result_rd_o      <= slot_rd[head];
            result_data_o    <= slot_data[head];
            result_illegal_o <= slot_illegal[head];
        end
    end

endmodule

`default_nettype wire

/* logic/exec_cluster.sv */
/*
 * Execute cluster top level
 * Dispatcher, four execute lanes and the in-order commit unit
 */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  logic                               instr_valid_i,
    input  logic [31:0]                        instr_i,
    input  logic [exec_pkg::XLEN-1:0]          operand_a_i,
    input  logic [exec_pkg::XLEN-1:0]          operand_b_i,
    output logic                               result_valid_o,
    output logic [exec_pkg::REG_ADDR_BITS-1:0] result_rd_o,
    output logic [exec_pkg::XLEN-1:0]          result_data_o,
    output logic                               result_illegal_o
);
    import exec_pkg::*;

    // Dispatcher to lanes
    logic [NR_LANES-1:0]      lane_valid;
    logic [ALU_OP_BITS-1:0]   iss_op;
    logic [XLEN-1:0]          iss_a;
    logic [XLEN-1:0]          iss_b;
    logic [REG_ADDR_BITS-1:0] iss_rd;
    logic                     iss_illegal;
    logic [TRANS_ID_BITS-1:0] iss_trans_id;

    // Lanes to commit
    logic [NR_LANES-1:0]               lane_done;
    logic [NR_LANES*TRANS_ID_BITS-1:0] lane_trans_id;
    logic [NR_LANES*REG_ADDR_BITS-1:0] lane_rd;
    logic [NR_LANES*XLEN-1:0]          lane_result;
    logic [NR_LANES-1:0]               lane_illegal;

    issue_dispatch i_dispatch (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( flush_i       ),
        .instr_valid_i ( instr_valid_i ),
        .instr_i       ( instr_i       ),
        .operand_a_i   ( operand_a_i   ),
        .operand_b_i   ( operand_b_i   ),
        .lane_valid_o  ( lane_valid    ),
        .op_o          ( iss_op        ),
        .op_a_o        ( iss_a         ),
        .op_b_o        ( iss_b         ),
        .rd_o          ( iss_rd        ),
        .illegal_o     ( iss_illegal   ),
        .trans_id_o    ( iss_trans_id  )
    );

    for (genvar l = 0; l < NR_LANES; l++) begin : g_lane
        exec_lane i_lane (
            .clk_i      ( clk_i                                            ),
            .rst_ni     ( rst_ni                                           ),
            .flush_i    ( flush_i                                          ),
            .valid_i    ( lane_valid[l]                                    ),
            .op_i       ( iss_op                                           ),
            .op_a_i     ( iss_a                                            ),
            .op_b_i     ( iss_b                                            ),
            .rd_i       ( iss_rd                                           ),
            .illegal_i  ( iss_illegal                                      ),
            .trans_id_i ( iss_trans_id                                     ),
            .done_o     ( lane_done[l]                                     ),
            .trans_id_o ( lane_trans_id[l*TRANS_ID_BITS +: TRANS_ID_BITS]  ),
            .rd_o       ( lane_rd[l*REG_ADDR_BITS +: REG_ADDR_BITS]        ),
            .result_o   ( lane_result[l*XLEN +: XLEN]                      ),
            .illegal_o  ( lane_illegal[l]                                  )
        );
    end

    commit_reorder i_commit (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .flush_i          ( flush_i          ),
        .done_i           ( lane_done        ),
        .trans_id_i       ( lane_trans_id    ),
        .rd_i             ( lane_rd          ),
        .result_i         ( lane_result      ),
        .illegal_i        ( lane_illegal     ),
        .result_valid_o   ( result_valid_o   ),
        .result_rd_o      ( result_rd_o      ),
        .result_data_o    ( result_data_o    ),
        .result_illegal_o ( result_illegal_o )
    );

endmodule

`default_nettype wire

/* logic/exec_lane.sv */
/*
 * Execute lane
 * Single-cycle ALU plus a four-step iterative multiplier that
 * keeps the low 64 bits of the product
 */
`timescale 1ns/1ps
`default_nettype none

module exec_lane (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 flush_i,
    input  logic                                 valid_i,
    input  logic [exec_pkg::ALU_OP_BITS-1:0]     op_i,
    input  logic [exec_pkg::XLEN-1:0]            op_a_i,
    input  logic [exec_pkg::XLEN-1:0]            op_b_i,
    input  logic [exec_pkg::REG_ADDR_BITS-1:0]   rd_i,
    input  logic                                 illegal_i,
    input  logic [exec_pkg::TRANS_ID_BITS-1:0]   trans_id_i,
    output logic                                 done_o,
    output logic [exec_pkg::TRANS_ID_BITS-1:0]   trans_id_o,
    output logic [exec_pkg::REG_ADDR_BITS-1:0]   rd_o,
    output logic [exec_pkg::XLEN-1:0]            result_o,
    output logic                                 illegal_o
);
    import exec_pkg::*;

    logic [XLEN-1:0]         alu_res;
    logic                    mul_start;
    logic                    mul_busy;
    logic                    mul_last;
    logic [MUL_CNT_BITS-1:0] mul_cnt;
    logic [XLEN-1:0]         mul_a;
    logic [XLEN-1:0]         mul_b;
    logic [XLEN-1:0]         mul_acc;
    logic [XLEN-1:0]         step_a;
    logic [XLEN-1:0]         step_b;
    logic [XLEN-1:0]         step_sum;

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        unique case (op_i)
            ALU_ADD:  alu_res = op_a_i + op_b_i;
            ALU_SUB:  alu_res = op_a_i - op_b_i;
            ALU_SLL:  alu_res = op_a_i << op_b_i[5:0];
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a_i < op_b_i};
            ALU_XOR:  alu_res = op_a_i ^ op_b_i;
            ALU_SRL:  alu_res = op_a_i >> op_b_i[5:0];
            ALU_SRA:  alu_res = $unsigned($signed(op_a_i) >>> op_b_i[5:0]);
            ALU_OR:   alu_res = op_a_i | op_b_i;
            ALU_AND:  alu_res = op_a_i & op_b_i;
            default:  alu_res = '0;
        endcase
        if (illegal_i) alu_res = '0;
    end

    // --------------------
    // Multiplier step
    // --------------------
    // First step runs straight from the lane inputs
    assign mul_start = valid_i && (op_i == ALU_MUL);
    assign mul_last  = mul_busy && (mul_cnt == MUL_CNT_BITS'(MUL_CYCLES - 1));
    assign step_a    = mul_busy ? mul_a : op_a_i;
    assign step_b    = {{(XLEN-MUL_STEP_BITS){1'b0}},
                        mul_busy ? mul_b[MUL_STEP_BITS-1:0] : op_b_i[MUL_STEP_BITS-1:0]};
    assign step_sum  = (mul_busy ? mul_acc : '0) + step_a * step_b;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_o   <= 1'b0;
            mul_busy <= 1'b0;
            mul_cnt  <= '0;
        end else if (flush_i) begin
            done_o   <= 1'b0;
            mul_busy <= 1'b0;
            mul_cnt  <= '0;
        end else begin
            done_o <= (valid_i && !mul_start) || mul_last;
            if (mul_start) begin
                mul_busy <= 1'b1;
                mul_cnt  <= MUL_CNT_BITS'(1);
            end else if (mul_last) begin
                mul_busy <= 1'b0;
            end else if (mul_busy) begin
                mul_cnt <= mul_cnt + 1'b1;
            end
        end
    end

    // Tag fields are held until done since the lane is not reused earlier
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            trans_id_o <= trans_id_i;
            rd_o       <= rd_i;
            illegal_o  <= illegal_i;
        end
        if (valid_i && !mul_start) result_o <= alu_res;
        else if (mul_last)         result_o <= step_sum;
        if (mul_start || mul_busy) begin
            mul_a   <= step_a << MUL_STEP_BITS;
            mul_b   <= (mul_busy ? mul_b : op_b_i) >> MUL_STEP_BITS;
            mul_acc <= step_sum;
        end
    end

endmodule

`default_nettype wire

/* logic/exec_pkg.sv */
/*
 * Execute cluster package
 * Widths, opcode values, internal operation codes and the
 * instruction word views shared by dispatch, lanes and commit
 */
`default_nettype none

package exec_pkg;

    // --------------------
    // Widths and sizes
    // --------------------
    localparam int XLEN           = 64;
    localparam int NR_LANES       = 4;
    localparam int LANE_ID_BITS   = 2;
    localparam int NR_ROB_ENTRIES = 8;
    localparam int TRANS_ID_BITS  = 3;
    localparam int REG_ADDR_BITS  = 5;

    // Iterative multiplier, 16 bits of operand B per step
    localparam int MUL_CYCLES    = 4;
    localparam int MUL_STEP_BITS = XLEN / MUL_CYCLES;
    localparam int MUL_CNT_BITS  = 2;

    // --------------------
    // Major opcodes
    // --------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // --------------------
    // Operation codes
    // --------------------
    localparam int ALU_OP_BITS = 4;

    localparam logic [ALU_OP_BITS-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_BITS-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_BITS-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_BITS-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_BITS-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_BITS-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_BITS-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_BITS-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_BITS-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_BITS-1:0] ALU_AND  = 4'd9;
    localparam logic [ALU_OP_BITS-1:0] ALU_MUL  = 4'd10;
    // Carried by illegal instructions
    localparam logic [ALU_OP_BITS-1:0] ALU_NOP  = 4'd15;

    // --------------------
    // Instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0]               funct7;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]              imm;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } i_type_t;

    // Same 32-bit word, register or immediate view
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

endpackage

`default_nettype wire

/* logic/issue_dispatch.sv */
/*
 * Issue dispatcher
 * Decodes R-type and I-type words into an operation and a second
 * operand, tags each with a transaction id and hands it to the
 * next execute lane in round-robin order
 */
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 flush_i,
    input  logic                                 instr_valid_i,
    input  exec_pkg::instr_t                     instr_i,
    input  logic [exec_pkg::XLEN-1:0]            operand_a_i,
    input  logic [exec_pkg::XLEN-1:0]            operand_b_i,
    output logic [exec_pkg::NR_LANES-1:0]        lane_valid_o,
    output logic [exec_pkg::ALU_OP_BITS-1:0]     op_o,
    output logic [exec_pkg::XLEN-1:0]            op_a_o,
    output logic [exec_pkg::XLEN-1:0]            op_b_o,
    output logic [exec_pkg::REG_ADDR_BITS-1:0]   rd_o,
    output logic                                 illegal_o,
    output logic [exec_pkg::TRANS_ID_BITS-1:0]   trans_id_o
);
    import exec_pkg::*;

    logic [ALU_OP_BITS-1:0]   dec_op;
    logic [XLEN-1:0]          dec_b;
    logic                     dec_illegal;
    logic [LANE_ID_BITS-1:0]  lane_ptr;
    logic [TRANS_ID_BITS-1:0] trans_cnt;

    // --------------------
    // Decode
    // --------------------
    always_comb begin
        dec_op      = ALU_NOP;
        dec_b       = operand_b_i;
        dec_illegal = 1'b0;
        if (instr_i.r.opcode == OPCODE_OP) begin
            unique case (instr_i.r.funct7)
                7'b0000000: begin
                    unique case (instr_i.r.funct3)
                        3'b000: dec_op = ALU_ADD;
                        3'b001: dec_op = ALU_SLL;
                        3'b010: dec_op = ALU_SLT;
                        3'b011: dec_op = ALU_SLTU;
                        3'b100: dec_op = ALU_XOR;
                        3'b101: dec_op = ALU_SRL;
                        3'b110: dec_op = ALU_OR;
                        default: dec_op = ALU_AND;
                    endcase
                end
                7'b0100000: begin
                    if (instr_i.r.funct3 == 3'b000)      dec_op = ALU_SUB;
                    else if (instr_i.r.funct3 == 3'b101) dec_op = ALU_SRA;
                    else                                 dec_illegal = 1'b1;
                end
                // M extension, only the low product is kept
                7'b0000001: begin
                    if (instr_i.r.funct3 == 3'b000) dec_op = ALU_MUL;
                    else                            dec_illegal = 1'b1;
                end
                default: dec_illegal = 1'b1;
            endcase
        end else if (instr_i.i.opcode == OPCODE_OP_IMM) begin
            dec_b = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
            unique case (instr_i.i.funct3)
                3'b000: dec_op = ALU_ADD;
                3'b010: dec_op = ALU_SLT;
                3'b011: dec_op = ALU_SLTU;
                3'b100: dec_op = ALU_XOR;
                3'b110: dec_op = ALU_OR;
                3'b111: dec_op = ALU_AND;
                3'b001: begin
                    dec_b = {{(XLEN-6){1'b0}}, instr_i.i.imm[5:0]};
                    if (instr_i.i.imm[11:6] == 6'b000000) dec_op = ALU_SLL;
                    else                                  dec_illegal = 1'b1;
                end
                default: begin
                    // Shift right, imm[10] picks arithmetic
                    dec_b = {{(XLEN-6){1'b0}}, instr_i.i.imm[5:0]};
                    if (instr_i.i.imm[11:6] == 6'b000000)      dec_op = ALU_SRL;
                    else if (instr_i.i.imm[11:6] == 6'b010000) dec_op = ALU_SRA;
                    else                                       dec_illegal = 1'b1;
                end
            endcase
        end else begin
            dec_illegal = 1'b1;
        end
        if (dec_illegal) dec_op = ALU_NOP;
    end

    // --------------------
    // Round-robin issue
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lane_valid_o <= '0;
            lane_ptr     <= '0;
            trans_cnt    <= '0;
        end else if (flush_i) begin
            lane_valid_o <= '0;
            lane_ptr     <= '0;
            trans_cnt    <= '0;
        end else begin
            lane_valid_o <= '0;
            if (instr_valid_i) begin
                lane_valid_o[lane_ptr] <= 1'b1;
                lane_ptr               <= lane_ptr + 1'b1;
                trans_cnt              <= trans_cnt + 1'b1;
            end
        end
    end

    // Broadcast payload, qualified by the lane strobe
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            op_o       <= dec_op;
            op_a_o     <= operand_a_i;
            op_b_o     <= dec_b;
            rd_o       <= instr_i.r.rd;
            illegal_o  <= dec_illegal;
            trans_id_o <= trans_cnt;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the execute cluster testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f compile.f --top-module exec_cluster_tb \
    -o exec_cluster_sim || { echo "Verilator build failed"; exit 1; }
sim_out=$(./obj_dir/exec_cluster_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "STATUS: PASS" && exit 0 || exit 1

/* verif/exec_cluster_tb.sv */
/*
 * Execute cluster testbench
 * Directed tests for the R-type and I-type ALU operations, MUL,
 * out-of-order completion, illegal words and flush, checked
 * against a reference model in program order
 */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;
    import exec_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RAND_PER_OP = 4;
    // R-type, I-type, MUL, mixed, illegal and flush tests
    localparam int NR_INSTR    = 10 * RAND_PER_OP + 21 + 8 + 8 + 8 + 7;

    logic            clk_i;
    logic            rst_ni;
    logic            flush_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] operand_a_i;
    logic [XLEN-1:0] operand_b_i;
    logic            result_valid_o;
    logic [4:0]      result_rd_o;
    logic [XLEN-1:0] result_data_o;
    logic            result_illegal_o;

    integer          seed;

    // Expected results in program order
    logic [4:0]      exp_rd_q[$];
    logic [XLEN-1:0] exp_data_q[$];
    logic            exp_ill_q[$];

    exec_cluster DUT (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .flush_i          ( flush_i          ),
        .instr_valid_i    ( instr_valid_i    ),
        .instr_i          ( instr_i          ),
        .operand_a_i      ( operand_a_i      ),
        .operand_b_i      ( operand_b_i      ),
        .result_valid_o   ( result_valid_o   ),
        .result_rd_o      ( result_rd_o      ),
        .result_data_o    ( result_data_o    ),
        .result_illegal_o ( result_illegal_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // Reporting
    // --------------------
    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [4:0] rand_rd();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, rand_rd(), rand_rd(), f3, rand_rd(), OPCODE_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, rand_rd(), f3, rand_rd(), OPCODE_OP_IMM};
    endfunction

    // RV64I and M reference rules
    function automatic void ref_result(input logic [31:0] w, input logic [63:0] a,
                                       input logic [63:0] b, output logic [63:0] data,
                                       output logic illegal);
        logic [63:0] imm;
        logic [5:0]  shamt;
        logic [6:0]  f7;
        logic [2:0]  f3;
        f7      = w[31:25];
        f3      = w[14:12];
        imm     = {{52{w[31]}}, w[31:20]};
        shamt   = w[25:20];
        data    = '0;
        illegal = 1'b0;
        if (w[6:0] == 7'b0110011) begin
            if (f7 == 7'b0000000) begin
                case (f3)
                    3'd0: data = a + b;
                    3'd1: data = a << b[5:0];
                    3'd2: data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    3'd3: data = (a < b) ? 64'd1 : 64'd0;
                    3'd4: data = a ^ b;
                    3'd5: data = a >> b[5:0];
                    3'd6: data = a | b;
                    default: data = a & b;
                endcase
            end else if (f7 == 7'b0100000 && f3 == 3'd0) begin
                data = a - b;
            end else if (f7 == 7'b0100000 && f3 == 3'd5) begin
                data = $unsigned($signed(a) >>> b[5:0]);
            end else if (f7 == 7'b0000001 && f3 == 3'd0) begin
                data = a * b;
            end else begin
                illegal = 1'b1;
            end
        end else if (w[6:0] == 7'b0010011) begin
            case (f3)
                3'd0: data = a + imm;
                3'd2: data = ($signed(a) < $signed(imm)) ? 64'd1 : 64'd0;
                3'd3: data = (a < imm) ? 64'd1 : 64'd0;
                3'd4: data = a ^ imm;
                3'd6: data = a | imm;
                3'd7: data = a & imm;
                3'd1: begin
                    if (w[31:26] == 6'b000000) data = a << shamt;
                    else illegal = 1'b1;
                end
                default: begin
                    if (w[31:26] == 6'b000000) data = a >> shamt;
                    else if (w[31:26] == 6'b010000) data = $unsigned($signed(a) >>> shamt);
                    else illegal = 1'b1;
                end
            endcase
        end else begin
            illegal = 1'b1;
        end
        if (illegal) data = '0;
    endfunction

    // One-cycle strobe, expectation queued first
    task automatic send_instr(input logic [31:0] w, input logic [63:0] a, input logic [63:0] b);
        logic [63:0] data;
        logic        illegal;
        ref_result(w, a, b, data, illegal);
        exp_rd_q.push_back(w[11:7]);
        exp_data_q.push_back(data);
        exp_ill_q.push_back(illegal);
        instr_i       = w;
        operand_a_i   = a;
        operand_b_i   = b;
        instr_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        instr_valid_i = 1'b0;
    endtask

    // Wait for every expected result, then a few idle cycles
    task automatic drain();
        while (exp_rd_q.size() != 0) @(posedge clk_i);
        repeat (3) @(posedge clk_i);
        #2;
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic r_type_ops();
        for (int k = 0; k < RAND_PER_OP; k++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                send_instr(r_type_word(7'h00, 3'(f3)), rand64(), rand64());
            end
            send_instr(r_type_word(7'h20, 3'd0), rand64(), rand64());
            send_instr(r_type_word(7'h20, 3'd5), rand64(), rand64());
        end
        drain();
    endtask

    task automatic i_type_ops();
        logic [63:0] r;
        logic [63:0] a;
        logic [5:0]  shamt;
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 1 && f3 != 5) begin
                r = rand64();
                send_instr(i_type_word({1'b0, r[10:0]}, 3'(f3)), rand64(), rand64());
                send_instr(i_type_word({1'b1, r[26:16]}, 3'(f3)), rand64(), rand64());
            end
        end
        // Shift amounts 0, 63 and one random
        for (int k = 0; k < 3; k++) begin
            r     = rand64();
            shamt = (k == 0) ? 6'd0 : (k == 1) ? 6'd63 : r[5:0];
            a     = rand64() | 64'h8000_0000_0000_0000;
            send_instr(i_type_word({6'b000000, shamt}, 3'd1), a, rand64());
            send_instr(i_type_word({6'b000000, shamt}, 3'd5), a, rand64());
            send_instr(i_type_word({6'b010000, shamt}, 3'd5), a, rand64());
        end
        drain();
    endtask

    task automatic mul_random();
        repeat (8) send_instr(r_type_word(7'h01, 3'd0), rand64(), rand64());
        drain();
    endtask

    // ADDs finish ahead of the MUL before them
    task automatic mixed_order();
        repeat (2) begin
            send_instr(r_type_word(7'h01, 3'd0), rand64(), rand64());
            repeat (3) send_instr(r_type_word(7'h00, 3'd0), rand64(), rand64());
        end
        drain();
    endtask

    task automatic illegal_words();
        send_instr(r_type_word(7'h00, 3'd0), rand64(), rand64());
        // Load opcode
        send_instr({12'h123, 5'd3, 3'b011, 5'd9, 7'b0000011}, rand64(), rand64());
        send_instr(r_type_word(7'h00, 3'd4), rand64(), rand64());
        send_instr(r_type_word(7'h20, 3'd1), rand64(), rand64());
        // MULH is not supported
        send_instr(r_type_word(7'h01, 3'd1), rand64(), rand64());
        send_instr(r_type_word(7'h02, 3'd0), rand64(), rand64());
        send_instr(i_type_word(12'h041, 3'd1), rand64(), rand64());
        send_instr(r_type_word(7'h20, 3'd0), rand64(), rand64());
        drain();
    endtask

    task automatic flush_in_flight();
        send_instr(r_type_word(7'h01, 3'd0), rand64(), rand64());
        send_instr(r_type_word(7'h00, 3'd0), rand64(), rand64());
        send_instr(r_type_word(7'h00, 3'd0), rand64(), rand64());
        // MUL still busy, nothing committed yet
        flush_i = 1'b1;
        exp_rd_q.delete();
        exp_data_q.delete();
        exp_ill_q.delete();
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        send_instr(r_type_word(7'h00, 3'd0), rand64(), rand64());
        send_instr(r_type_word(7'h01, 3'd0), rand64(), rand64());
        send_instr(r_type_word(7'h20, 3'd0), rand64(), rand64());
        send_instr(r_type_word(7'h00, 3'd4), rand64(), rand64());
        drain();
    endtask

    // --------------------
    // Monitor and watchdog
    // --------------------
    always @(negedge clk_i) begin : monitor
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        logic        e_ill;
        if (rst_ni && result_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("[ERROR] %0t: a result came out with no instruction expected", $time);
                stop_run();
            end else begin
                e_rd   = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_ill  = exp_ill_q.pop_front();
                compare("result_rd_o", 64'(result_rd_o), 64'(e_rd));
                compare("result_data_o", result_data_o, e_data);
                compare("result_illegal_o", 64'(result_illegal_o), 64'(e_ill));
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (NR_INSTR * 8 + 200));
        $display("[ERROR] %0t: watchdog timeout, the tests did not finish", $time);
        stop_run();
    end

    initial begin
        seed          = 3;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        operand_a_i   = '0;
        operand_b_i   = '0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        compare("result_valid_o", 64'(result_valid_o), 64'd0);
        @(posedge clk_i);
        #2;
        r_type_ops();
        i_type_ops();
        mul_random();
        mixed_order();
        illegal_words();
        flush_in_flight();
        drain();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
